// ==== list.f ====
source/spi_reg_pkg.sv
source/spi_pin_sync.sv
source/spi_byte_shifter.sv
source/spi_frame_decoder.sv
source/spi_register_bank.sv
source/spi_reg_top.sv
tb/spi_reg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the spi register port testbench with verilator, run it and check the result.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module spi_reg_tb -o spi_reg_sim \
	&& sim_out=$(./obj_dir/spi_reg_sim) \
	|| { echo "build or simulation run failed"; exit 1; }

echo "$sim_out"
echo "$sim_out" | grep -qx "All tests passed" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// ==== tb/spi_reg_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_reg_tb;

	localparam int sck_half = 4; // clk cycles per sck phase, one byte is 64 cycles.
	// about 140 bytes at 64 cycles plus frame gaps comes to ~10000 cycles, doubled.
	localparam int timeout_cycles = 20000;

	logic                   clk = 1'b0;
	logic                   rst_n;
	logic                   spi_sck;
	logic                   spi_mosi;
	logic                   spi_cs_n;
	logic                   spi_miso;
	spi_reg_pkg::wr_event_t wr_event;

	logic [spi_reg_pkg::data_width-1:0] model_regs [spi_reg_pkg::reg_count]; // reference copy.
	spi_reg_pkg::wr_event_t             exp_writes [$]; // writes still to be reported.
	spi_reg_pkg::wr_event_t             exp_ev;
	logic [31:0]                        rng_state;
	logic                               cmd_phase = 1'b0; // master is clocking a command byte.
	int                                 err_cnt = 0;
	int                                 err_base = 0;     // err_cnt when the test began.
	int                                 pass_cnt = 0;
	int                                 fail_cnt = 0;
	int                                 cycle_cnt = 0;

	always #2 clk = ~clk; // 4 ns period.

	spi_reg_top spi_reg_top_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.spi_sck  (spi_sck),
		.spi_mosi (spi_mosi),
		.spi_cs_n (spi_cs_n),
		.spi_miso (spi_miso),
		.wr_event (wr_event)
	);

	// ********************
	// helpers
	// ********************

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] draw_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// mode 0, msb first; nbits below 8 cuts the byte short.
	task automatic spi_transfer(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
		rx = '0;
		for (int i = 7; i > 7 - nbits; i--) begin
			spi_sck  = 1'b0;
			spi_mosi = tx[i];  // changes while sck is low.
			wait_cycles(sck_half);
			spi_sck = 1'b1;
			rx[i]   = spi_miso; // sampled as sck rises.
			wait_cycles(sck_half);
		end
		spi_sck = 1'b0;
	endtask

	task automatic open_frame(input logic [7:0] cmd);
		logic [7:0] rx;
		spi_cs_n = 1'b0;
		wait_cycles(6);    // cs_fall reaches the shifter after ~4.5 cycles.
		cmd_phase = 1'b1;
		spi_transfer(cmd, 8, rx);
		cmd_phase = 1'b0;
	endtask

	// gap covers the 7 cycle write path and the last prefetch.
	task automatic close_frame();
		wait_cycles(sck_half);
		spi_cs_n = 1'b1;
		wait_cycles(12);
	endtask

	task automatic write_frame(input logic [3:0] start, input int len);
		logic [3:0]             addr;
		logic [7:0]             rx;
		logic [31:0]            r;
		spi_reg_pkg::wr_event_t ev;
		addr = start;
		r    = draw_random();
		open_frame({1'b0, r[6:4], start}); // bits 6:4 carry junk.
		for (int i = 0; i < len; i++) begin
			r        = draw_random();
			ev.valid = 1'b1;
			ev.addr  = addr;
			ev.data  = r[7:0];
			exp_writes.push_back(ev);
			model_regs[addr] = r[7:0];
			spi_transfer(r[7:0], 8, rx);
			addr = addr + 4'd1; // wraps modulo 16.
		end
		close_frame();
	endtask

	task automatic read_frame(input logic [3:0] start, input int len);
		logic [3:0]  addr;
		logic [7:0]  rx;
		logic [31:0] r;
		addr = start;
		r    = draw_random();
		open_frame({1'b1, r[6:4], start});
		for (int i = 0; i < len; i++) begin
			r = draw_random();
			spi_transfer(r[7:0], 8, rx); // mosi is don't care here.
			assert (rx === model_regs[addr]) else begin
				$display("[ERROR] t=%0t spi_miso byte for addr %0d expected %02h got %02h",
					$time, addr, model_regs[addr], rx);
				err_cnt++;
			end
			addr = addr + 4'd1;
		end
		close_frame();
	endtask

	task automatic finish_test(input int num, input string name);
		if (exp_writes.size() != 0) begin
			$display("t=%0t test %0d: %0d expected write events never appeared",
				$time, num, exp_writes.size());
			err_cnt++;
			exp_writes.delete();
		end
		if (err_cnt == err_base) begin
			pass_cnt++;
			$display("test %0d %s: ok", num, name);
		end else begin
			fail_cnt++;
			$display("test %0d %s: failed with %0d errors", num, name, err_cnt - err_base);
		end
		err_base = err_cnt;
	endtask

	// ********************
	// checkers
	// ********************

	// miso stays low while the command byte is clocked.
	assert property (@(posedge clk) disable iff (!rst_n) !(cmd_phase && spi_miso))
		else begin
			$display("[ERROR] t=%0t spi_miso expected 0 got %b in command byte",
				$time, $sampled(spi_miso));
			err_cnt++;
		end

	always @(negedge clk) begin
		if (rst_n && wr_event.valid) begin
			if (exp_writes.size() == 0) begin
				$display("t=%0t write event to addr %0d arrived with none expected",
					$time, wr_event.addr);
				err_cnt++;
			end else begin
				exp_ev = exp_writes.pop_front(); // oldest write first.
				assert (wr_event.addr === exp_ev.addr) else begin
					$display("[ERROR] t=%0t wr_event.addr expected %0d got %0d",
						$time, exp_ev.addr, wr_event.addr);
					err_cnt++;
				end
				assert (wr_event.data === exp_ev.data) else begin
					$display("[ERROR] t=%0t wr_event.data expected %02h got %02h",
						$time, exp_ev.data, wr_event.data);
					err_cnt++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == timeout_cycles) begin
			$display("run timed out after %0d cycles", timeout_cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	// ********************
	// stimulus
	// ********************

	initial begin
		logic [7:0]  rx;
		logic [31:0] r;
		spi_sck   = 1'b0;
		spi_mosi  = 1'b0;
		spi_cs_n  = 1'b1; // deselected.
		rst_n     = 1'b0;
		rng_state = 32'd57;
		for (int i = 0; i < spi_reg_pkg::reg_count; i++) begin
			model_regs[i] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		wait_cycles(4);

		read_frame(4'd0, 16);
		finish_test(1, "burst read after reset");

		write_frame(4'd6, 1);
		read_frame(4'd6, 1);
		finish_test(2, "single write and read back");

		write_frame(4'd14, 4); // events at 14, 15, 0, 1.
		finish_test(3, "burst write with wrap");

		read_frame(4'd15, 5);
		finish_test(4, "burst read with wrap");

		// data byte cut after five bits, then a fresh command.
		r = draw_random();
		open_frame({1'b0, 3'b000, 4'd9});
		spi_transfer(r[7:0], 5, rx);
		close_frame();
		read_frame(4'd9, 1);
		finish_test(5, "partial byte dropped");

		for (int f = 0; f < 20; f++) begin
			r = draw_random();
			if (r[8]) begin
				read_frame(r[3:0], 1 + int'(r[13:12]));
			end else begin
				write_frame(r[3:0], 1 + int'(r[13:12]));
			end
		end
		finish_test(6, "random frames");

		$display("summary: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/spi_reg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_reg_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   spi_sck,
	input  logic                   spi_mosi,
	input  logic                   spi_cs_n,
	output logic                   spi_miso,
	output spi_reg_pkg::wr_event_t wr_event
);

	spi_reg_pkg::pin_event_t pin_event; // pins into the clk domain.
	spi_reg_pkg::rx_byte_t   rx_byte;   // completed bytes.
	spi_reg_pkg::reg_req_t   reg_req;   // decoder to bank.
	spi_reg_pkg::reg_rsp_t   reg_rsp;   // read data back to the shifter.

	// ********************
	// pipeline
	// ********************

	spi_pin_sync spi_pin_sync_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.spi_sck   (spi_sck),
		.spi_mosi  (spi_mosi),
		.spi_cs_n  (spi_cs_n),
		.pin_event (pin_event)
	);

	spi_byte_shifter spi_byte_shifter_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.pin_event (pin_event),
		.tx_load   (reg_rsp),
		.spi_miso  (spi_miso),
		.rx_byte   (rx_byte)
	);

	spi_frame_decoder spi_frame_decoder_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.pin_event (pin_event),
		.rx_byte   (rx_byte),
		.reg_req   (reg_req)
	);

	spi_register_bank spi_register_bank_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.reg_req  (reg_req),
		.reg_rsp  (reg_rsp),
		.wr_event (wr_event)
	);

endmodule

`default_nettype wire

// ==== source/spi_register_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_register_bank (
	input  logic                   clk,
	input  logic                   rst_n,
	input  spi_reg_pkg::reg_req_t  reg_req,
	output spi_reg_pkg::reg_rsp_t  reg_rsp,
	output spi_reg_pkg::wr_event_t wr_event
);

	logic [spi_reg_pkg::data_width-1:0] regs [spi_reg_pkg::reg_count]; // the register file.
	logic                               rsp_valid;
	logic [spi_reg_pkg::data_width-1:0] rsp_rdata;
	logic                               ev_valid;
	logic [spi_reg_pkg::addr_width-1:0] ev_addr;
	logic [spi_reg_pkg::data_width-1:0] ev_data;

	// ********************
	// storage
	// ********************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < spi_reg_pkg::reg_count; i++) begin
				regs[i] <= '0; // every register resets to zero.
			end
		end else if (reg_req.wr) begin
			regs[reg_req.addr] <= reg_req.wdata;
		end
	end

	// ********************
	// strobes
	// ********************

	// read return and write report, one cycle after the request.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
			ev_valid  <= 1'b0;
		end else begin
			rsp_valid <= reg_req.rd;
			ev_valid  <= reg_req.wr;
		end
	end

	// payload follows its strobe.
	always_ff @(posedge clk) begin
		if (reg_req.rd) begin
			rsp_rdata <= regs[reg_req.addr];
		end
		if (reg_req.wr) begin
			ev_addr <= reg_req.addr;
			ev_data <= reg_req.wdata;
		end
	end

	assign reg_rsp.valid  = rsp_valid;
	assign reg_rsp.rdata  = rsp_rdata;
	assign wr_event.valid = ev_valid;
	assign wr_event.addr  = ev_addr;
	assign wr_event.data  = ev_data;

endmodule

`default_nettype wire

// ==== source/spi_frame_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_frame_decoder (
	input  logic                    clk,
	input  logic                    rst_n,
	input  spi_reg_pkg::pin_event_t pin_event,
	input  spi_reg_pkg::rx_byte_t   rx_byte,
	output spi_reg_pkg::reg_req_t   reg_req
);

	typedef enum logic {
		st_cmd,  // waiting for the command byte.
		st_data  // data bytes until cs# rises.
	} state_t;

	state_t                             state;
	logic                               is_read;   // frame direction.
	logic [spi_reg_pkg::addr_width-1:0] cur_addr;  // address of the current data byte.
	logic [spi_reg_pkg::addr_width-1:0] next_addr;
	logic [spi_reg_pkg::addr_width-1:0] cmd_addr;  // start address field of the command.
	logic                               cmd_read;
	logic                               req_wr;
	logic                               req_rd;
	logic [spi_reg_pkg::addr_width-1:0] req_addr;
	logic [spi_reg_pkg::data_width-1:0] req_wdata;

	assign next_addr = cur_addr + 1'b1;                             // wraps modulo 16.
	assign cmd_addr  = rx_byte.data[spi_reg_pkg::addr_width-1:0];  // bits 6:4 ignored.
	assign cmd_read  = rx_byte.data[spi_reg_pkg::cmd_read_bit];

	// ********************
	// frame FSM
	// ********************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= st_cmd;
			is_read  <= 1'b0;
			cur_addr <= '0;
			req_wr   <= 1'b0;
			req_rd   <= 1'b0;
		end else begin
			req_wr <= 1'b0;
			req_rd <= 1'b0;
			if (pin_event.cs_fall || pin_event.cs_rise) begin
				state <= st_cmd; // either edge starts over with a command.
			end else if (rx_byte.valid) begin
				case (state)
					st_cmd: begin
						is_read  <= cmd_read;
						cur_addr <= cmd_addr;
						req_rd   <= cmd_read;  // first read byte fetched at once.
						state    <= st_data;
					end
					st_data: begin
						cur_addr <= next_addr;
						if (is_read) begin
							req_rd <= 1'b1;       // prefetch for the next byte.
						end else begin
							req_wr <= 1'b1;
						end
					end
					default: state <= st_cmd;
				endcase
			end
		end
	end

	// ********************
	// request payload
	// ********************

	always_ff @(posedge clk) begin
		if (rx_byte.valid) begin
			req_wdata <= rx_byte.data;
			if (state == st_cmd) begin
				req_addr <= cmd_addr;
			end else if (is_read) begin
				req_addr <= next_addr; // read ahead of the master.
			end else begin
				req_addr <= cur_addr;  // write lands on the current address.
			end
		end
	end

	assign reg_req.wr    = req_wr;
	assign reg_req.rd    = req_rd;
	assign reg_req.addr  = req_addr;
	assign reg_req.wdata = req_wdata;

endmodule

`default_nettype wire

// ==== source/spi_byte_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_byte_shifter (
	input  logic                    clk,
	input  logic                    rst_n,
	input  spi_reg_pkg::pin_event_t pin_event,
	input  spi_reg_pkg::reg_rsp_t   tx_load,
	output logic                    spi_miso,
	output spi_reg_pkg::rx_byte_t   rx_byte
);

	logic [$clog2(spi_reg_pkg::data_width)-1:0] bit_cnt; // bit position in the byte.
	logic [spi_reg_pkg::data_width-1:0]         rx_sr;   // receive shift register.
	logic [spi_reg_pkg::data_width-1:0]         tx_sr;   // transmit shift register.
	logic [spi_reg_pkg::data_width-1:0]         rx_data; // last completed byte.
	logic                                       rx_valid;
	logic                                       last_bit;

	// eighth bit of the current byte.
	assign last_bit = (bit_cnt == ($bits(bit_cnt))'(spi_reg_pkg::data_width - 1));

	// ********************
	// receive side
	// ********************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bit_cnt  <= '0;
			rx_sr    <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0; // strobe.
			if (pin_event.cs_fall) begin
				bit_cnt <= '0;   // new frame, drop any partial byte.
				rx_sr   <= '0;
			end else if (pin_event.sck_rise) begin
				bit_cnt  <= bit_cnt + 1'b1; // wraps after eight bits.
				rx_sr    <= {rx_sr[spi_reg_pkg::data_width-2:0], pin_event.mosi};
				rx_valid <= last_bit;
			end
		end
	end

	// byte capture, msb first.
	always_ff @(posedge clk) begin
		if (pin_event.sck_rise && last_bit) begin
			rx_data <= {rx_sr[spi_reg_pkg::data_width-2:0], pin_event.mosi};
		end
	end

	assign rx_byte.valid = rx_valid;
	assign rx_byte.data  = rx_data;

	// ********************
	// transmit side
	// ********************

	// a load wins over a clear in the same cycle.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tx_sr <= '0;
		end else if (tx_load.valid) begin
			tx_sr <= tx_load.rdata;
		end else if (pin_event.cs_fall) begin
			tx_sr <= '0;                                           // zeros during the command byte.
		end else if (pin_event.sck_rise) begin
			tx_sr <= {tx_sr[spi_reg_pkg::data_width-2:0], 1'b0}; // next bit after each rise.
		end
	end

	// msb goes out as soon as the read data arrives, one cycle ahead of the load.
	assign spi_miso = tx_load.valid ? tx_load.rdata[spi_reg_pkg::data_width-1]
		: tx_sr[spi_reg_pkg::data_width-1];

endmodule

`default_nettype wire

// ==== source/spi_pin_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_pin_sync (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   spi_sck,
	input  logic                   spi_mosi,
	input  logic                   spi_cs_n,
	output spi_reg_pkg::pin_event_t pin_event
);

	// ********************
	// synchronizers
	// ********************

	logic [2:0] sck_sync;  // bit 0 is the first flop.
	logic [2:0] mosi_sync;
	logic [2:0] cs_n_sync;
	logic       sck_prev;  // one more copy of sck for edge detection.
	logic       cs_n_prev; // same for cs#.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sck_sync  <= '0;
			mosi_sync <= '0;
			cs_n_sync <= '1;   // deselected, no false cs_fall out of reset.
			sck_prev  <= 1'b0;
			cs_n_prev <= 1'b1;
		end else begin
			sck_sync  <= {sck_sync[1:0], spi_sck};
			mosi_sync <= {mosi_sync[1:0], spi_mosi};
			cs_n_sync <= {cs_n_sync[1:0], spi_cs_n};
			sck_prev  <= sck_sync[2];
			cs_n_prev <= cs_n_sync[2];
		end
	end

	// ********************
	// edge flops
	// ********************

	// events are registered, so a pin edge shows up four cycles later.
	// mosi goes through the same depth and lines up with sck_rise.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pin_event <= '0;
		end else begin
			pin_event.sck_rise <= sck_sync[2] & ~sck_prev;
			pin_event.cs_fall  <= cs_n_prev & ~cs_n_sync[2];  // select.
			pin_event.cs_rise  <= ~cs_n_prev & cs_n_sync[2];  // deselect.
			pin_event.mosi     <= mosi_sync[2];
		end
	end

endmodule

`default_nettype wire

// ==== source/spi_reg_pkg.sv ====
`default_nettype none

package spi_reg_pkg;

	// ********************
	// register port sizes
	// ********************

	localparam int reg_count    = 16; // registers in the bank.
	localparam int addr_width   = 4;  // log2 of reg_count.
	localparam int data_width   = 8;  // one spi byte per register.
	localparam int cmd_read_bit = 7;  // set in the command byte for a read.

	// ********************
	// stage payloads
	// ********************

	// pin stage output, all in the clk domain.
	typedef struct packed {
		logic sck_rise; // one cycle per synchronized sck rising edge.
		logic cs_fall;  // frame start.
		logic cs_rise;  // frame end.
		logic mosi;     // aligned with sck_rise.
	} pin_event_t;

	typedef struct packed {
		logic                  valid; // one cycle per completed byte.
		logic [data_width-1:0] data;
	} rx_byte_t;

	// register access request from the decoder.
	typedef struct packed {
		logic                  wr;
		logic                  rd;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] wdata;
	} reg_req_t;

	typedef struct packed {
		logic                  valid; // read data ready.
		logic [data_width-1:0] rdata;
	} reg_rsp_t;

	// completed write, reported at the top level.
	typedef struct packed {
		logic                  valid;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] data;
	} wr_event_t;

endpackage

`default_nettype wire
